/* Makefile */
# Verilator build and run for the writeback stage testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= sim
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)

run: build
	./$(OBJ_DIR)/$(SIM_BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* rtl/wb_arch_regs.sv */
`timescale 1ns/100ps

module wb_arch_regs
    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    wb_wr_if.dst     wr,
    input  reg_idx_t gpr_rd_idx,
    output gpr_t     gpr_rd_data,
    input  reg_idx_t seg_rd_idx,
    output seg_t     seg_rd_data
);

    gpr_t gpr [GPR_COUNT];
    seg_t seg [SEG_COUNT];

    // slots applied in order so a later slot overrides an earlier one,
    // partial writes leave the upper bits of an earlier write in place
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < GPR_COUNT; r++)
                gpr[r] <= '0;
            for (int s = 0; s < SEG_COUNT; s++)
                seg[s] <= '0;
        end else begin
            for (int i = 0; i < SLOTS; i++) begin
                if (wr.reg_ld[i]) begin
                    case (wr.size)
                        SIZE_8:  gpr[wr.dest[i]][7:0]  <= wr.data[i][7:0];
                        SIZE_16: gpr[wr.dest[i]][15:0] <= wr.data[i][15:0];
                        SIZE_32: gpr[wr.dest[i]]       <= wr.data[i][31:0];
                        SIZE_64: gpr[wr.dest[i]]       <= wr.data[i][31:0];    // upper half dropped
                    endcase
                end
                if (wr.seg_ld[i] && (int'(wr.dest[i]) < SEG_COUNT))
                    seg[wr.dest[i]] <= wr.data[i][15:0];    // selector only
            end
        end
    end

    assign gpr_rd_data = gpr[gpr_rd_idx];

    always_comb begin
        if (int'(seg_rd_idx) < SEG_COUNT)
            seg_rd_data = seg[seg_rd_idx];
        else
            seg_rd_data = '0;   // no segment at 6, 7
    end

endmodule

/* rtl/wb_ctrl_pkg.sv */
package wb_ctrl_pkg;

    import wb_types_pkg::*;

    localparam int P_OP_W = 37;     // micro-op word

    // any of bits 36, 35, 32 marks a far jmp/call/ret
    localparam logic [P_OP_W-1:0] P_OP_FAR_BITS = (37'd1 << 36) | (37'd1 << 35) | (37'd1 << 32);

    // operand size codes
    localparam size_t SIZE_8  = 2'b00;
    localparam size_t SIZE_16 = 2'b01;
    localparam size_t SIZE_32 = 2'b10;
    localparam size_t SIZE_64 = 2'b11;

    // segment index of cs
    localparam reg_idx_t CS_IDX = 3'd1;

    // exception type, low bits are the fault code
    typedef logic [3:0] ie_type_t;

    localparam int IE_EXT_BIT = 3;  // set for external interrupt

endpackage

/* rtl/wb_ifc.sv */
`timescale 1ns/100ps

// register file write bus, one lane per result slot
interface wb_wr_if
    import wb_types_pkg::*;
();
    logic [SLOTS-1:0] reg_ld;
    logic [SLOTS-1:0] seg_ld;
    reg_idx_t         dest [SLOTS];
    result_t          data [SLOTS];
    size_t            size;     // shared by all slots

    modport src (
        output reg_ld, seg_ld, dest, data, size
    );

    modport dst (
        input reg_ld, seg_ld, dest, data, size
    );
endinterface

// memory write queue push side
interface mem_wr_if
    import wb_types_pkg::*;
();
    logic    push;
    addr_t   addr;
    result_t data;
    size_t   size;
    logic    full;

    modport src (
        output push, addr, data, size,
        input  full
    );

    modport dst (
        input  push, addr, data, size,
        output full
    );
endinterface

/* rtl/wb_mem_queue.sv */
`timescale 1ns/100ps

module wb_mem_queue
    import wb_types_pkg::*;
#(
    parameter int DEPTH = MEMQ_DEPTH
) (
    input  logic     clk,
    input  logic     arst_n,
    mem_wr_if.dst    wq,
    input  logic     mem_ready,
    output logic     mem_valid,
    output addr_t    mem_addr,
    output result_t  mem_data,
    output size_t    mem_size
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    addr_t   addr_q [DEPTH];
    result_t data_q [DEPTH];
    size_t   size_q [DEPTH];
    ptr_t    wr_ptr;
    ptr_t    rd_ptr;
    cnt_t    count;
    logic    pop;

    function automatic ptr_t next_ptr(input ptr_t p);
        next_ptr = (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wq.full   = (count == cnt_t'(DEPTH));
    assign mem_valid = (count != '0);
    assign pop       = mem_valid & mem_ready;

    // head entry
    assign mem_addr = addr_q[rd_ptr];
    assign mem_data = data_q[rd_ptr];
    assign mem_size = size_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (wq.push) begin
            addr_q[wr_ptr] <= wq.addr;
            data_q[wr_ptr] <= wq.data;
            size_q[wr_ptr] <= wq.size;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wq.push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({wq.push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or push with pop
            endcase
        end
    end

endmodule

/* rtl/wb_stage.sv */
`timescale 1ns/100ps

module wb_stage
    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;
(
    input  logic              valid_in,
    input  addr_t             eip_in,
    input  result_t           slot1_data, slot2_data, slot3_data, slot4_data,
    input  addr_t             slot1_dest, slot2_dest, slot3_dest, slot4_dest,
    input  logic              slot1_is_reg, slot2_is_reg, slot3_is_reg, slot4_is_reg,
    input  logic              slot1_is_seg, slot2_is_seg, slot3_is_seg, slot4_is_seg,
    input  logic              slot1_is_mem, slot2_is_mem, slot3_is_mem, slot4_is_mem,
    input  size_t             res_size,
    input  logic [P_OP_W-1:0] p_op,
    input  logic              br_valid,
    input  logic              br_taken,
    input  logic              br_correct,
    input  addr_t             br_target,
    input  logic              ie_in,
    input  ie_type_t          ie_type_in,
    input  logic              interrupt_in,
    wb_wr_if.src              wr,
    mem_wr_if.src             mem,
    output logic              valid_out,
    output logic              stall,
    output addr_t             new_eip,
    output addr_t             fip_even,
    output addr_t             fip_odd,
    output logic              redirect,
    output logic              final_ie_val,
    output ie_type_t          final_ie_type
);

    result_t          data_a [SLOTS];
    addr_t            dest_a [SLOTS];
    logic [SLOTS-1:0] is_reg_v;
    logic [SLOTS-1:0] is_seg_v;
    logic [SLOTS-1:0] is_mem_v;
    logic             far_xfer;
    logic             any_mem;
    addr_t            target_eip;
    addr_t            line_base;
    addr_t            line_next;

    assign data_a = '{slot1_data, slot2_data, slot3_data, slot4_data};
    assign dest_a = '{slot1_dest, slot2_dest, slot3_dest, slot4_dest};

    assign is_reg_v = {slot4_is_reg, slot3_is_reg, slot2_is_reg, slot1_is_reg};
    assign is_seg_v = {slot4_is_seg, slot3_is_seg, slot2_is_seg, slot1_is_seg};
    assign is_mem_v = {slot4_is_mem, slot3_is_mem, slot2_is_mem, slot1_is_mem};

    assign far_xfer = |(p_op & P_OP_FAR_BITS);  // far jmp/call/ret
    assign any_mem  = |is_mem_v;

    // queue full only matters when this instruction writes memory
    assign stall     = valid_in & any_mem & mem.full;
    assign valid_out = valid_in & ~stall;

    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            wr.reg_ld[i] = is_reg_v[i] & valid_out;
            wr.seg_ld[i] = is_seg_v[i] & valid_out;
            wr.dest[i]   = dest_a[i][2:0];
            wr.data[i]   = data_a[i];
        end
        // far transfer turns slot 1 into the cs load
        if (far_xfer) begin
            wr.reg_ld[0] = 1'b0;
            wr.seg_ld[0] = valid_out;
            wr.dest[0]   = CS_IDX;
            wr.data[0]   = {48'd0, slot1_data[47:32]};
        end
    end

    assign wr.size = res_size;

    // lowest memory slot wins
    always_comb begin
        mem.addr = dest_a[0];
        mem.data = data_a[0];
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (is_mem_v[i]) begin
                mem.addr = dest_a[i];
                mem.data = data_a[i];
            end
        end
    end

    assign mem.push = valid_out & any_mem;
    assign mem.size = far_xfer ? SIZE_64 : res_size;    // eip:cs pair on far

    assign target_eip = far_xfer ? slot1_data[31:0] : br_target;
    assign new_eip    = br_taken ? target_eip : eip_in;

    // 16-byte fetch lines, split by bit 4 into even and odd banks
    assign line_base = {new_eip[31:4], 4'd0};
    assign line_next = line_base + 32'd16;
    assign fip_even  = line_base[4] ? line_next : line_base;
    assign fip_odd   = line_base[4] ? line_base : line_next;

    assign redirect = valid_out & br_valid & ~br_correct;   // mispredict resteer

    assign final_ie_val = ie_in | interrupt_in;

    always_comb begin
        final_ie_type             = ie_type_in;
        final_ie_type[IE_EXT_BIT] = interrupt_in;
    end

endmodule

/* rtl/wb_top.sv */
`timescale 1ns/100ps

module wb_top
    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              valid_in,
    input  addr_t             eip_in,
    input  result_t           slot1_data, slot2_data, slot3_data, slot4_data,
    input  addr_t             slot1_dest, slot2_dest, slot3_dest, slot4_dest,
    input  logic              slot1_is_reg, slot2_is_reg, slot3_is_reg, slot4_is_reg,
    input  logic              slot1_is_seg, slot2_is_seg, slot3_is_seg, slot4_is_seg,
    input  logic              slot1_is_mem, slot2_is_mem, slot3_is_mem, slot4_is_mem,
    input  size_t             res_size,
    input  logic [P_OP_W-1:0] p_op,
    input  logic              br_valid,
    input  logic              br_taken,
    input  logic              br_correct,
    input  addr_t             br_target,
    input  logic              ie_in,
    input  ie_type_t          ie_type_in,
    input  logic              interrupt_in,
    input  logic              mem_ready,
    input  reg_idx_t          gpr_rd_idx,
    input  reg_idx_t          seg_rd_idx,
    output logic              stall,
    output logic              valid_out,
    output addr_t             new_eip,
    output addr_t             fip_even,
    output addr_t             fip_odd,
    output logic              redirect,
    output logic              final_ie_val,
    output ie_type_t          final_ie_type,
    output logic              mem_valid,
    output addr_t             mem_addr,
    output result_t           mem_data,
    output size_t             mem_size,
    output gpr_t              gpr_rd_data,
    output seg_t              seg_rd_data
);

    wb_wr_if  wr_bus ();
    mem_wr_if mem_bus ();

    wb_stage u_stage (
        .valid_in      (valid_in),
        .eip_in        (eip_in),
        .slot1_data    (slot1_data),
        .slot2_data    (slot2_data),
        .slot3_data    (slot3_data),
        .slot4_data    (slot4_data),
        .slot1_dest    (slot1_dest),
        .slot2_dest    (slot2_dest),
        .slot3_dest    (slot3_dest),
        .slot4_dest    (slot4_dest),
        .slot1_is_reg  (slot1_is_reg),
        .slot2_is_reg  (slot2_is_reg),
        .slot3_is_reg  (slot3_is_reg),
        .slot4_is_reg  (slot4_is_reg),
        .slot1_is_seg  (slot1_is_seg),
        .slot2_is_seg  (slot2_is_seg),
        .slot3_is_seg  (slot3_is_seg),
        .slot4_is_seg  (slot4_is_seg),
        .slot1_is_mem  (slot1_is_mem),
        .slot2_is_mem  (slot2_is_mem),
        .slot3_is_mem  (slot3_is_mem),
        .slot4_is_mem  (slot4_is_mem),
        .res_size      (res_size),
        .p_op          (p_op),
        .br_valid      (br_valid),
        .br_taken      (br_taken),
        .br_correct    (br_correct),
        .br_target     (br_target),
        .ie_in         (ie_in),
        .ie_type_in    (ie_type_in),
        .interrupt_in  (interrupt_in),
        .wr            (wr_bus.src),
        .mem           (mem_bus.src),
        .valid_out     (valid_out),
        .stall         (stall),
        .new_eip       (new_eip),
        .fip_even      (fip_even),
        .fip_odd       (fip_odd),
        .redirect      (redirect),
        .final_ie_val  (final_ie_val),
        .final_ie_type (final_ie_type)
    );

    wb_mem_queue #(
        .DEPTH (MEMQ_DEPTH)
    ) u_memq (
        .clk       (clk),
        .arst_n    (arst_n),
        .wq        (mem_bus.dst),
        .mem_ready (mem_ready),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data),
        .mem_size  (mem_size)
    );

    wb_arch_regs u_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr          (wr_bus.dst),
        .gpr_rd_idx  (gpr_rd_idx),
        .gpr_rd_data (gpr_rd_data),
        .seg_rd_idx  (seg_rd_idx),
        .seg_rd_data (seg_rd_data)
    );

endmodule

/* rtl/wb_types_pkg.sv */
package wb_types_pkg;

    // datapath widths
    typedef logic [63:0] result_t;      // one result slot
    typedef logic [31:0] addr_t;        // linear address or eip
    typedef logic [31:0] gpr_t;
    typedef logic [15:0] seg_t;         // segment selector
    typedef logic [2:0]  reg_idx_t;     // gpr or segment index
    typedef logic [1:0]  size_t;        // operand size code

    // result slots per instruction
    localparam int SLOTS = 4;

    // architectural register counts
    localparam int GPR_COUNT = 8;
    localparam int SEG_COUNT = 6;       // es cs ss ds fs gs

    // pending memory writes
    localparam int MEMQ_DEPTH = 4;

endpackage

/* sources.f */
rtl/wb_types_pkg.sv
rtl/wb_ctrl_pkg.sv
rtl/wb_ifc.sv
rtl/wb_stage.sv
rtl/wb_mem_queue.sv
rtl/wb_arch_regs.sv
rtl/wb_top.sv
testbench/wb_properties.sv
testbench/tb_wb_top.sv

/* testbench/tb_wb_top.sv */
`timescale 1ns/100ps

module tb_wb_top
    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;
();

    typedef struct packed {
        addr_t    eip;
        addr_t    even;
        addr_t    odd;
        logic     redirect;
        logic     ie_val;
        ie_type_t ie_type;
    } expect_t;

    logic clk;
    logic arst_n;
    logic valid_in;
    addr_t eip_in;
    result_t s_data [SLOTS];
    addr_t s_dest [SLOTS];
    logic [SLOTS-1:0] s_reg;
    logic [SLOTS-1:0] s_seg;
    logic [SLOTS-1:0] s_mem;
    size_t res_size;
    logic [P_OP_W-1:0] p_op;
    logic br_valid, br_taken, br_correct;
    addr_t br_target;
    logic ie_in;
    ie_type_t ie_type_in;
    logic interrupt_in;
    logic mem_ready;
    reg_idx_t gpr_rd_idx, seg_rd_idx;
    logic stall, valid_out, redirect, final_ie_val, mem_valid;
    addr_t new_eip, fip_even, fip_odd, mem_addr;
    ie_type_t final_ie_type;
    result_t mem_data;
    size_t mem_size;
    gpr_t gpr_rd_data;
    seg_t seg_rd_data;

    integer seed = 68;
    int rdy_mode = 2;           // 0 low, 1 high, 2 random
    logic rdy_next;
    gpr_t m_gpr [GPR_COUNT];
    seg_t m_seg [SEG_COUNT];
    addr_t q_addr [$];
    result_t q_data [$];
    size_t q_size [$];

    wb_top u_wb_top (
        .clk (clk), .arst_n (arst_n), .valid_in (valid_in), .eip_in (eip_in),
        .slot1_data (s_data[0]), .slot2_data (s_data[1]),
        .slot3_data (s_data[2]), .slot4_data (s_data[3]),
        .slot1_dest (s_dest[0]), .slot2_dest (s_dest[1]),
        .slot3_dest (s_dest[2]), .slot4_dest (s_dest[3]),
        .slot1_is_reg (s_reg[0]), .slot2_is_reg (s_reg[1]),
        .slot3_is_reg (s_reg[2]), .slot4_is_reg (s_reg[3]),
        .slot1_is_seg (s_seg[0]), .slot2_is_seg (s_seg[1]),
        .slot3_is_seg (s_seg[2]), .slot4_is_seg (s_seg[3]),
        .slot1_is_mem (s_mem[0]), .slot2_is_mem (s_mem[1]),
        .slot3_is_mem (s_mem[2]), .slot4_is_mem (s_mem[3]),
        .res_size (res_size), .p_op (p_op), .br_valid (br_valid),
        .br_taken (br_taken), .br_correct (br_correct), .br_target (br_target),
        .ie_in (ie_in), .ie_type_in (ie_type_in), .interrupt_in (interrupt_in),
        .mem_ready (mem_ready), .gpr_rd_idx (gpr_rd_idx), .seg_rd_idx (seg_rd_idx),
        .stall (stall), .valid_out (valid_out), .new_eip (new_eip),
        .fip_even (fip_even), .fip_odd (fip_odd), .redirect (redirect),
        .final_ie_val (final_ie_val), .final_ie_type (final_ie_type),
        .mem_valid (mem_valid), .mem_addr (mem_addr), .mem_data (mem_data),
        .mem_size (mem_size), .gpr_rd_data (gpr_rd_data), .seg_rd_data (seg_rd_data)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act)
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            abort_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    endtask

    task automatic check_gpr(input string name, input gpr_t exp, input gpr_t act);
        if (exp !== act)
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_seg(input string name, input seg_t exp, input seg_t act);
        if (exp !== act)
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_ie(input string name, input ie_type_t exp, input ie_type_t act);
        if (exp !== act)
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_mem(input string name, input addr_t exp_a, input result_t exp_d,
                             input size_t exp_s, input addr_t act_a, input result_t act_d,
                             input size_t act_s);
        if (exp_a !== act_a || exp_d !== act_d || exp_s !== act_s)
            abort_run($sformatf("MISMATCH %s expected %h/%h/%0d actual %h/%h/%0d",
                                name, exp_a, exp_d, exp_s, act_a, act_d, act_s));
    endtask

    // expected stage outputs from the writeback rules
    function automatic expect_t predict(input addr_t eip, input logic far, input logic taken,
                                        input addr_t target, input result_t slot1,
                                        input logic accepted, input logic bv, input logic bc,
                                        input logic ie, input ie_type_t ie_t,
                                        input logic intr);
        expect_t e;
        addr_t   line;
        if (!taken)
            e.eip = eip;
        else if (far)
            e.eip = slot1[31:0];
        else
            e.eip = target;
        line = {e.eip[31:4], 4'h0};
        e.even     = line[4] ? line + 32'd16 : line;
        e.odd      = line[4] ? line : line + 32'd16;
        e.redirect = accepted & bv & ~bc;
        e.ie_val   = ie | intr;
        e.ie_type  = {intr, ie_t[2:0]};
        return e;
    endfunction

    task automatic rand_instr(input bit want_mem, input int far_bit);
        int kind;
        for (int i = 0; i < SLOTS; i++) begin
            kind = $unsigned($random(seed)) % 4;
            s_reg[i]  = (kind == 0);
            s_seg[i]  = (kind == 1);
            s_mem[i]  = (kind == 2) && want_mem;
            s_data[i] = {$random(seed), $random(seed)};
            s_dest[i] = $random(seed);
        end
        res_size = size_t'($random(seed));
        p_op = P_OP_W'({$random(seed), $random(seed)}) & ~P_OP_FAR_BITS;
        if (far_bit >= 0)
            p_op[far_bit] = 1'b1;
        eip_in       = $random(seed);
        br_target    = $random(seed);
        br_valid     = 1'($random(seed));
        br_taken     = 1'($random(seed));
        br_correct   = 1'($random(seed));
        ie_in        = 1'($random(seed));
        ie_type_in   = ie_type_t'($random(seed));
        interrupt_in = 1'($random(seed));
    endtask

    // called 1 ns after an edge, returns one edge later
    task automatic run_instr(input string name, output logic accepted);
        expect_t e;
        logic    far;
        logic    exp_stall;
        reg_idx_t idx;
        int      j;
        far       = |(p_op & P_OP_FAR_BITS);
        exp_stall = (|s_mem) && (q_addr.size() == MEMQ_DEPTH);
        accepted  = !exp_stall;
        valid_in  = 1'b1;
        #2;
        e = predict(eip_in, far, br_taken, br_target, s_data[0], accepted, br_valid,
                    br_correct, ie_in, ie_type_in, interrupt_in);
        check_bit({name, " stall"}, exp_stall, stall);
        check_bit({name, " valid_out"}, accepted, valid_out);
        check_addr({name, " new_eip"}, e.eip, new_eip);
        check_addr({name, " fip_even"}, e.even, fip_even);
        check_addr({name, " fip_odd"}, e.odd, fip_odd);
        check_bit({name, " redirect"}, e.redirect, redirect);
        check_bit({name, " ie_val"}, e.ie_val, final_ie_val);
        check_ie({name, " ie_type"}, e.ie_type, final_ie_type);
        if (accepted) begin
            for (int i = 0; i < SLOTS; i++) begin
                idx = s_dest[i][2:0];
                if (far && i == 0) begin
                    m_seg[CS_IDX] = s_data[0][47:32];
                end else begin
                    if (s_reg[i]) begin
                        case (res_size)
                            SIZE_8:  m_gpr[idx][7:0]  = s_data[i][7:0];
                            SIZE_16: m_gpr[idx][15:0] = s_data[i][15:0];
                            default: m_gpr[idx]       = s_data[i][31:0];
                        endcase
                    end
                    if (s_seg[i] && int'(idx) < SEG_COUNT)
                        m_seg[idx] = s_data[i][15:0];
                end
            end
            j = -1;
            for (int i = SLOTS - 1; i >= 0; i--)
                if (s_mem[i])
                    j = i;
            if (j >= 0) begin
                q_addr.push_back(s_dest[j]);
                q_data.push_back(s_data[j]);
                q_size.push_back(far ? SIZE_64 : res_size);
            end
        end
        @(posedge clk);
        #1;
        valid_in = 1'b0;
    endtask

    // one register pair per cycle
    task automatic readback(input string name);
        for (int r = 0; r < GPR_COUNT; r++) begin
            gpr_rd_idx = reg_idx_t'(r);
            seg_rd_idx = reg_idx_t'(r);
            #2;
            check_gpr($sformatf("%s gpr%0d", name, r), m_gpr[r], gpr_rd_data);
            check_seg($sformatf("%s seg%0d", name, r),
                      (r < SEG_COUNT) ? m_seg[r] : seg_t'(0), seg_rd_data);
            @(posedge clk);
            #1;
        end
    endtask

    // next mem_ready drawn at negedge, driven after the rising edge
    always begin
        @(negedge clk);
        if (rdy_mode == 2)
            rdy_next = 1'($random(seed));
        else
            rdy_next = (rdy_mode == 1);
        @(posedge clk);
        #1;
        mem_ready = rdy_next;
    end

    // drained entries in FIFO order, sampled mid cycle
    always @(negedge clk) begin
        if (arst_n && mem_valid && mem_ready) begin
            if (q_addr.size() == 0) begin
                abort_run("memory port drained an entry that was never written");
            end else begin
                check_mem("mem drain", q_addr[0], q_data[0], q_size[0],
                          mem_addr, mem_data, mem_size);
                void'(q_addr.pop_front());
                void'(q_data.pop_front());
                void'(q_size.pop_front());
            end
        end
    end

    initial begin
        logic acc;
        int   n;
        clk = 1'b0;
        arst_n = 1'b0;
        valid_in = 1'b0;
        mem_ready = 1'b0;
        gpr_rd_idx = '0;
        seg_rd_idx = '0;
        rand_instr(1'b0, -1);
        foreach (m_gpr[r]) m_gpr[r] = '0;
        foreach (m_seg[s]) m_seg[s] = '0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        readback("reset");

        for (int k = 0; k < 60; k++) begin     // regs, memory, branch, exceptions
            rand_instr(1'b1, -1);
            run_instr($sformatf("random%0d", k), acc);
            readback($sformatf("random%0d", k));
        end

        for (int b = P_OP_W - 1; b >= 0; b--) begin
            if (P_OP_FAR_BITS[b]) begin
                rand_instr(1'b0, b);
                s_mem = 4'b0010;
                br_taken = 1'b1;
                run_instr($sformatf("far bit%0d", b), acc);
                readback($sformatf("far bit%0d", b));
            end
        end

        rdy_mode = 0;
        acc = 1'b1;
        n = 0;
        while (acc) begin
            if (n == 2 * MEMQ_DEPTH + 8)
                abort_run("queue never filled with the memory port held off");
            rand_instr(1'b0, -1);
            s_mem[0] = 1'b1;
            run_instr("fill", acc);
            n++;
        end
        readback("stalled");
        rdy_mode = 1;
        n = 0;
        acc = 1'b0;
        while (!acc) begin
            if (n == 16)
                abort_run("stalled instruction was never accepted");
            run_instr("retry", acc);
            n++;
        end
        readback("retry");

        n = 0;
        while (q_addr.size() != 0) begin
            if (n == 100)
                abort_run("memory queue did not drain");
            @(posedge clk);
            n++;
        end
        @(posedge clk);
        #1;
        if (mem_valid)
            abort_run("mem_valid still high after all writes drained");
        else
            $display("Regression passed");
        $finish;
    end

endmodule

/* testbench/wb_properties.sv */
`timescale 1ns/100ps

module wb_properties #(
    parameter int DEPTH = 4
) (
    input logic                       clk,
    input logic                       arst_n,
    input logic                       push,
    input logic                       full,
    input logic                       mem_valid,
    input logic [$clog2(DEPTH+1)-1:0] count
);

    // stage must hold off while the queue is full
    no_push_when_full: assert property (
        @(posedge clk) disable iff (!arst_n) !(push && full)
    ) else $error("push while queue full");

    empty_after_reset: assert property (
        @(posedge clk) $rose(arst_n) |-> !mem_valid
    ) else $error("mem_valid high after reset");

    count_in_range: assert property (
        @(posedge clk) disable iff (!arst_n) count <= ($clog2(DEPTH+1))'(DEPTH)
    ) else $error("queue occupancy above depth");

endmodule

bind wb_mem_queue wb_properties #(
    .DEPTH (DEPTH)
) u_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (wq.push),
    .full      (wq.full),
    .mem_valid (mem_valid),
    .count     (count)
);
